//--- Makefile
# Verilator lint, simulation and clean for the board test

VERILATOR  ?= verilator
FILELIST   ?= filelist.f
TB_TOP     ?= tb_csa_test_top
RTL_TOP    ?= csa_test_top
OBJ_DIR    ?= obj_dir
SIM_FLAGS  ?= --binary --timing --timescale 1ns/100ps -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
RTL_SRCS   ?= $(shell grep '^src/' $(FILELIST))
PASS_MSG   ?= Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -o $(TB_TOP)
	./$(OBJ_DIR)/$(TB_TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- filelist.f
src/fx2_pkg.sv
src/fx2_fifo_ctrl.sv
src/test_pattern_gen.sv
src/ctrl_status_regs.sv
src/seg_scan.sv
src/csa_test_top.sv
tb/fx2_host_model.sv
tb/tb_csa_test_top.sv

//--- src/csa_test_top.sv
// Board test top level: slave-FIFO controller, pattern source,
// command registers and seven-segment scanner
`default_nettype none

module csa_test_top #(
        parameter int PKT_WORDS = 256,
        parameter int SCAN_DIV  = 16
) (
        input  wire                          usbclk,
        input  wire                          arst_n,
        input  wire                          flaga,
        input  wire                          flagb,
        input  wire                          flagc,
        output logic                         slcs,
        output logic                         sloe,
        output logic                         slrd,
        output logic                         slwr,
        output logic                         pktend,
        output fx2_pkg::fifo_adr_t           fifoadr,
        input  wire fx2_pkg::word_t          fd_in,
        output fx2_pkg::word_t               fd_out,
        output logic                         fd_oe,          // Pad buffer enable in wrapper
        output logic [fx2_pkg::DIGITS-1:0]   ledseg,
        output logic [7:0]                   seg_d
);
        import fx2_pkg::*;

        word_t             ep2_data;
        word_t             ep6_data;
        word_t             ep8_data;
        word_t             disp_value;
        logic              ep2_valid;
        logic              ep2_take;
        logic              ep6_strobe;
        logic              ep8_strobe;
        logic              flush;
        logic              gen_enable;
        logic [STEP_W-1:0] gen_step;

        fx2_fifo_ctrl #(
                .PKT_WORDS (PKT_WORDS)
        ) u_fifo_ctrl (
                .usbclk     (usbclk),
                .arst_n     (arst_n),
                .flaga      (flaga),
                .flagb      (flagb),
                .flagc      (flagc),
                .fd_in      (fd_in),
                .ep2_data   (ep2_data),
                .ep2_valid  (ep2_valid),
                .flush      (flush),
                .slcs       (slcs),
                .sloe       (sloe),
                .slrd       (slrd),
                .slwr       (slwr),
                .pktend     (pktend),
                .fifoadr    (fifoadr),
                .fd_out     (fd_out),
                .fd_oe      (fd_oe),
                .ep2_take   (ep2_take),
                .ep6_data   (ep6_data),
                .ep6_strobe (ep6_strobe),
                .ep8_data   (ep8_data),
                .ep8_strobe (ep8_strobe)
        );

        test_pattern_gen u_pattern_gen (
                .usbclk     (usbclk),
                .arst_n     (arst_n),
                .gen_enable (gen_enable),
                .gen_step   (gen_step),
                .ep2_take   (ep2_take),
                .ep2_data   (ep2_data),
                .ep2_valid  (ep2_valid)
        );

        // Pattern word doubles as the display source when the sum is not selected
        ctrl_status_regs u_regs (
                .usbclk        (usbclk),
                .arst_n        (arst_n),
                .ep8_data      (ep8_data),
                .ep8_strobe    (ep8_strobe),
                .ep6_data      (ep6_data),
                .ep6_strobe    (ep6_strobe),
                .pattern_value (ep2_data),
                .gen_enable    (gen_enable),
                .gen_step      (gen_step),
                .flush         (flush),
                .disp_value    (disp_value)
        );

        seg_scan #(
                .SCAN_DIV (SCAN_DIV)
        ) u_seg_scan (
                .usbclk     (usbclk),
                .arst_n     (arst_n),
                .disp_value (disp_value),
                .ledseg     (ledseg),
                .seg_d      (seg_d)
        );

endmodule

`default_nettype wire

//--- src/ctrl_status_regs.sv
// EP8 command decoder with control and step registers,
// EP6 running sum and display source select
`default_nettype none

module ctrl_status_regs (
        input  wire                          usbclk,
        input  wire                          arst_n,
        input  wire fx2_pkg::word_t          ep8_data,
        input  wire                          ep8_strobe,
        input  wire fx2_pkg::word_t          ep6_data,
        input  wire                          ep6_strobe,
        input  wire fx2_pkg::word_t          pattern_value,
        output logic                         gen_enable,
        output logic [fx2_pkg::STEP_W-1:0]   gen_step,
        output logic                         flush,
        output fx2_pkg::word_t               disp_value
);
        import fx2_pkg::*;

        reg_adr_t cmd_adr;
        logic     disp_sel;     // 1 shows the EP6 sum
        word_t    ep6_sum;

        assign cmd_adr = reg_adr_t'(ep8_data[15:12]);

        always_ff @(posedge usbclk or negedge arst_n) begin
                if (!arst_n) begin
                        gen_enable <= 1'b0;
                        disp_sel   <= 1'b0;
                        gen_step   <= '0;
                        flush      <= 1'b0;
                        ep6_sum    <= '0;
                end else begin
                        flush <= 1'b0;
                        if (ep6_strobe)
                                ep6_sum <= ep6_sum + ep6_data;  // Modulo 2^16
                        if (ep8_strobe) begin
                                case (cmd_adr)
                                REG_CTRL: begin
                                        // Falling enable commits a short EP2 packet
                                        flush      <= gen_enable & ~ep8_data[0];
                                        gen_enable <= ep8_data[0];
                                        disp_sel   <= ep8_data[1];
                                end
                                REG_STEP:
                                        gen_step <= ep8_data[STEP_W-1:0];
                                REG_SUM_CLR:
                                        ep6_sum <= '0;
                                default: begin
                                        // Unknown address, no effect
                                end
                                endcase
                        end
                end
        end

        assign disp_value = disp_sel ? ep6_sum : pattern_value;

endmodule

`default_nettype wire

//--- src/fx2_fifo_ctrl.sv
// Slave-FIFO controller for the USB bridge: endpoint arbitration,
// three-cycle strobe sequence, EP2 packet count and short packet commit
`default_nettype none

module fx2_fifo_ctrl #(
        parameter int PKT_WORDS = 256
) (
        input  wire                    usbclk,
        input  wire                    arst_n,
        input  wire                    flaga,          // EP6 has data
        input  wire                    flagb,          // EP8 has data
        input  wire                    flagc,          // EP2 has room
        input  wire fx2_pkg::word_t    fd_in,
        input  wire fx2_pkg::word_t    ep2_data,
        input  wire                    ep2_valid,
        input  wire                    flush,
        output logic                   slcs,
        output logic                   sloe,
        output logic                   slrd,
        output logic                   slwr,
        output logic                   pktend,
        output fx2_pkg::fifo_adr_t     fifoadr,
        output fx2_pkg::word_t         fd_out,
        output logic                   fd_oe,
        output logic                   ep2_take,
        output fx2_pkg::word_t         ep6_data,
        output logic                   ep6_strobe,
        output fx2_pkg::word_t         ep8_data,
        output logic                   ep8_strobe
);
        import fx2_pkg::*;

        localparam int CNT_W = (PKT_WORDS > 1) ? $clog2(PKT_WORDS) : 1;

        ctrl_state_t      state;
        fifo_adr_t        cur_adr;
        logic             is_read;        // OUT endpoint transfer
        logic             is_pkt;         // Short packet commit
        logic             pend_flush;     // Flush seen mid-transfer
        logic             cs_n;
        logic [CNT_W-1:0] pkt_cnt;        // Words in current EP2 packet
        logic             flush_req;

        assign flush_req = flush | pend_flush;

        always_ff @(posedge usbclk or negedge arst_n) begin
                if (!arst_n) begin
                        state      <= ST_IDLE;
                        cur_adr    <= ADR_EP2;
                        is_read    <= 1'b0;
                        is_pkt     <= 1'b0;
                        pend_flush <= 1'b0;
                        cs_n       <= 1'b1;
                        pkt_cnt    <= '0;
                end else begin
                        cs_n <= 1'b0;
                        if (flush && state != ST_IDLE)
                                pend_flush <= 1'b1;
                        case (state)
                        ST_IDLE: begin
                                is_pkt <= 1'b0;
                                if (flush_req) begin
                                        pend_flush <= 1'b0;
                                        if (pkt_cnt != '0) begin       // Empty packet needs no pktend
                                                cur_adr <= ADR_EP2;
                                                is_read <= 1'b0;
                                                is_pkt  <= 1'b1;
                                                state   <= ST_ADDR;
                                        end
                                end else if (flagb) begin      // Commands first
                                        cur_adr <= ADR_EP8;
                                        is_read <= 1'b1;
                                        state   <= ST_ADDR;
                                end else if (flaga) begin
                                        cur_adr <= ADR_EP6;
                                        is_read <= 1'b1;
                                        state   <= ST_ADDR;
                                end else if (flagc && ep2_valid) begin
                                        cur_adr <= ADR_EP2;
                                        is_read <= 1'b0;
                                        state   <= ST_ADDR;
                                end
                        end
                        ST_ADDR:
                                state <= is_pkt ? ST_PKTEND : ST_STROBE;
                        ST_STROBE: begin
                                if (!is_read) begin
                                        if (pkt_cnt == CNT_W'(PKT_WORDS - 1))
                                                pkt_cnt <= '0;  // Full packet goes out by itself
                                        else
                                                pkt_cnt <= pkt_cnt + 1'b1;
                                end
                                state <= ST_HOLD;
                        end
                        ST_HOLD:
                                state <= ST_IDLE;       // Flags settle here
                        ST_PKTEND: begin
                                pkt_cnt <= '0;
                                state   <= ST_IDLE;
                        end
                        default:
                                state <= ST_IDLE;
                        endcase
                end
        end

        // Sampled OUT words become one-cycle pulses to the register block
        always_ff @(posedge usbclk or negedge arst_n) begin
                if (!arst_n) begin
                        ep6_strobe <= 1'b0;
                        ep8_strobe <= 1'b0;
                end else begin
                        ep6_strobe <= (state == ST_STROBE) && is_read && (cur_adr == ADR_EP6);
                        ep8_strobe <= (state == ST_STROBE) && is_read && (cur_adr == ADR_EP8);
                end
        end

        always_ff @(posedge usbclk) begin
                if (state == ST_STROBE && is_read) begin
                        if (cur_adr == ADR_EP8)
                                ep8_data <= fd_in;
                        else
                                ep6_data <= fd_in;
                end
                if (state == ST_IDLE)
                        fd_out <= ep2_data;     // Held through the write
        end

        assign slcs     = cs_n;
        assign fifoadr  = cur_adr;
        assign sloe     = !(is_read && (state == ST_ADDR || state == ST_STROBE));
        assign slrd     = !(is_read && state == ST_STROBE);
        assign slwr     = !(!is_read && state == ST_STROBE);
        assign pktend   = (state != ST_PKTEND);
        assign ep2_take = !is_read && (state == ST_STROBE);
        assign fd_oe    = !is_read && !is_pkt &&
                          (state == ST_ADDR || state == ST_STROBE || state == ST_HOLD);

endmodule

`default_nettype wire

//--- src/fx2_pkg.sv
// Shared widths, bridge FIFO addresses, EP8 register addresses
// and the FIFO controller state encoding
`default_nettype none

package fx2_pkg;

        localparam int WORD_W = 16;     // Width of the fd bus
        localparam int STEP_W = 8;      // Pattern step field in REG_STEP
        localparam int DIGITS = 4;      // Seven-segment digits on the board

        typedef logic [WORD_W-1:0] word_t;

        // Bridge FIFO address as seen on fifoadr
        typedef enum logic [1:0] {
                ADR_EP2 = 2'd0,         // IN to host
                ADR_EP6 = 2'd2,         // Bulk OUT
                ADR_EP8 = 2'd3          // Command OUT
        } fifo_adr_t;

        typedef enum logic [2:0] {
                ST_IDLE,
                ST_ADDR,
                ST_STROBE,
                ST_HOLD,
                ST_PKTEND
        } ctrl_state_t;

        // Taken from bits 15:12 of an EP8 word
        typedef enum logic [3:0] {
                REG_CTRL    = 4'd0,
                REG_STEP    = 4'd1,
                REG_SUM_CLR = 4'd2
        } reg_adr_t;

endpackage

`default_nettype wire

//--- src/seg_scan.sv
// Multiplexed four-digit seven-segment scanner:
// refresh divider, digit select and hex decode
`default_nettype none

module seg_scan #(
        parameter int SCAN_DIV = 16
) (
        input  wire                          usbclk,
        input  wire                          arst_n,
        input  wire fx2_pkg::word_t          disp_value,
        output logic [fx2_pkg::DIGITS-1:0]   ledseg,         // Active-low digit enables
        output logic [7:0]                   seg_d           // Active-low, dp in bit 7
);
        import fx2_pkg::*;

        localparam int DIV_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
        localparam int SEL_W = $clog2(DIGITS);

        logic [DIV_W-1:0] div_cnt;
        logic [SEL_W-1:0] digit;
        logic             tick;
        logic [3:0]       nibble;

        // Segments g..a, active high
        function automatic logic [6:0] hex_seg(input logic [3:0] h);
                case (h)
                4'h0: hex_seg = 7'h3f;
                4'h1: hex_seg = 7'h06;
                4'h2: hex_seg = 7'h5b;
                4'h3: hex_seg = 7'h4f;
                4'h4: hex_seg = 7'h66;
                4'h5: hex_seg = 7'h6d;
                4'h6: hex_seg = 7'h7d;
                4'h7: hex_seg = 7'h07;
                4'h8: hex_seg = 7'h7f;
                4'h9: hex_seg = 7'h6f;
                4'ha: hex_seg = 7'h77;
                4'hb: hex_seg = 7'h7c;
                4'hc: hex_seg = 7'h39;
                4'hd: hex_seg = 7'h5e;
                4'he: hex_seg = 7'h79;
                default: hex_seg = 7'h71;
                endcase
        endfunction

        assign tick = (div_cnt == DIV_W'(SCAN_DIV - 1));

        always_ff @(posedge usbclk or negedge arst_n) begin
                if (!arst_n) begin
                        div_cnt <= '0;
                        digit   <= '0;
                        ledseg  <= {{(DIGITS - 1){1'b1}}, 1'b0};   // Digit 0 first
                end else if (tick) begin
                        div_cnt <= '0;
                        digit   <= (digit == SEL_W'(DIGITS - 1)) ? '0 : digit + 1'b1;
                        ledseg  <= {ledseg[DIGITS-2:0], ledseg[DIGITS-1]};
                end else begin
                        div_cnt <= div_cnt + 1'b1;
                end
        end

        assign nibble = disp_value[digit*4 +: 4];
        assign seg_d  = {1'b1, ~hex_seg(nibble)};       // Decimal point off

endmodule

`default_nettype wire

//--- src/test_pattern_gen.sv
// Stepping counter that feeds EP2 words to the FIFO controller
`default_nettype none

module test_pattern_gen (
        input  wire                          usbclk,
        input  wire                          arst_n,
        input  wire                          gen_enable,
        input  wire [fx2_pkg::STEP_W-1:0]    gen_step,
        input  wire                          ep2_take,
        output fx2_pkg::word_t               ep2_data,
        output logic                         ep2_valid
);
        import fx2_pkg::*;

        word_t value;           // Current pattern word
        word_t step_ext;

        assign step_ext = {{(WORD_W - STEP_W){1'b0}}, gen_step};

        // Advance only when the controller has written the word out
        always_ff @(posedge usbclk or negedge arst_n) begin
                if (!arst_n) begin
                        value <= '0;
                end else if (ep2_take) begin
                        value <= value + step_ext;      // Wraps modulo 2^16
                end
        end

        // Value is kept across a disable, so a restart resumes the sequence
        assign ep2_data  = value;
        assign ep2_valid = gen_enable;

endmodule

`default_nettype wire

//--- tb/fx2_host_model.sv
// Host side of the USB bridge slave FIFOs: EP6 and EP8 queues,
// EP2 room, and logs of written words, packet ends and reads
`default_nettype none

module fx2_host_model (
        input  wire                        usbclk,
        input  wire                        sloe,
        input  wire                        slrd,
        input  wire                        slwr,
        input  wire                        pktend,
        input  wire fx2_pkg::fifo_adr_t    fifoadr,
        input  wire fx2_pkg::word_t        fd_out,
        output logic                       flaga,
        output logic                       flagb,
        output logic                       flagc,
        output fx2_pkg::word_t             fd_in
);
        timeunit 1ns;
        timeprecision 100ps;
        import fx2_pkg::*;

        word_t     ep6_q[$];
        word_t     ep8_q[$];
        word_t     ep2_log[$];          // Words written by the DUT
        fifo_adr_t read_log[$];         // Endpoint of each OUT read, in order
        int        pktend_cnt = 0;
        int        ep2_room = 0;

        // Flags and read data follow the queues and the current address
        task automatic refresh();
                flaga = (ep6_q.size() != 0);
                flagb = (ep8_q.size() != 0);
                flagc = (ep2_room > 0);
                fd_in = '0;
                if (sloe == 1'b0 && fifoadr == ADR_EP8 && flagb)
                        fd_in = ep8_q[0];
                else if (sloe == 1'b0 && fifoadr == ADR_EP6 && flaga)
                        fd_in = ep6_q[0];
        endtask

        task automatic load_ep6(input word_t w);
                ep6_q.push_back(w);
                refresh();
        endtask

        task automatic load_ep8(input word_t w);
                ep8_q.push_back(w);
                refresh();
        endtask

        task automatic add_room(input int n);
                ep2_room += n;
                refresh();
        endtask

        initial refresh();

        // Strobes are taken at the edge, the bridge answers 1 ns later
        always @(posedge usbclk) begin
                if (slrd == 1'b0) begin
                        read_log.push_back(fifoadr);
                        if (fifoadr == ADR_EP8 && ep8_q.size() != 0)
                                void'(ep8_q.pop_front());
                        else if (fifoadr == ADR_EP6 && ep6_q.size() != 0)
                                void'(ep6_q.pop_front());
                end
                if (slwr == 1'b0) begin
                        ep2_log.push_back(fd_out);
                        ep2_room--;
                end
                if (pktend == 1'b0)
                        pktend_cnt++;
                #1 refresh();
        end

endmodule

`default_nettype wire

//--- tb/tb_csa_test_top.sv
// Testbench for the board test top: host FIFO model, LFSR stimulus,
// reference functions, compare tasks and cycle limit
`default_nettype none

module tb_csa_test_top;
        timeunit 1ns;
        timeprecision 100ps;
        import fx2_pkg::*;

        localparam int PKT_WORDS = 16;
        localparam int SCAN_DIV  = 16;
        localparam logic [7:0] SEG_LUT [16] = '{              // Active low, dp off
                8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99, 8'h92, 8'h82, 8'hf8,
                8'h80, 8'h90, 8'h88, 8'h83, 8'hc6, 8'ha1, 8'h86, 8'h8e};

        logic              usbclk;
        logic              arst_n;
        logic              flaga, flagb, flagc;
        logic              slcs, sloe, slrd, slwr, pktend, fd_oe;
        fifo_adr_t         fifoadr;
        word_t             fd_in, fd_out;
        logic [DIGITS-1:0] ledseg;
        logic [7:0]        seg_d;
        logic [31:0]       lfsr = 32'h9df98f2f;
        int                cycles = 0;
        int                cycle_limit = 2000;
        int                checked = 0;         // EP2 words compared so far
        int                round_start = 0;     // Log index of the round's first word
        word_t             round_base = '0;
        logic [7:0]        round_step = '0;

        csa_test_top #(.PKT_WORDS(PKT_WORDS), .SCAN_DIV(SCAN_DIV)) uut (.*);
        fx2_host_model host (.*);

        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return s[0] ? ((s >> 1) ^ 32'hd0000001) : (s >> 1);
        endfunction

        task automatic draw(input int nbits, output logic [31:0] v);
                v = '0;
                repeat (nbits) begin
                        lfsr = lfsr_next(lfsr);
                        v    = {v[30:0], lfsr[0]};
                end
        endtask

        // Word idx of a round that starts at base
        function automatic word_t exp_pattern(input word_t base, input logic [7:0] step,
                                              input int idx);
                logic [31:0] prod;
                prod = 32'(idx) * {24'h0, step};
                return base + prod[15:0];
        endfunction

        function automatic word_t sum_add(input word_t acc, input word_t w);
                return acc + w;         // Modulo 2^16
        endfunction

        function automatic int exp_pktends(input int n);
                return (n % PKT_WORDS != 0) ? 1 : 0;
        endfunction

        function automatic logic [7:0] ref_seg(input logic [3:0] h);
                return SEG_LUT[h];
        endfunction

        task automatic abort_run(input string what);
                $display("%s", what);
                $display("Simulation FAILED");
                $fatal(1, "run stopped at first error");
        endtask

        task automatic check_word(input string name, input word_t got, input word_t exp);
                if (got !== exp)
                        abort_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
        endtask

        task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
                if (got !== exp)
                        abort_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
        endtask

        task automatic check_count(input string name, input int got, input int exp);
                if (got != exp)
                        abort_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
        endtask

        task automatic check_adr(input string name, input fifo_adr_t got, input fifo_adr_t exp);
                if (got !== exp)
                        abort_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
        endtask

        initial begin
                usbclk = 1'b0;
                forever #2 usbclk = ~usbclk;
        end

        always @(posedge usbclk) begin
                cycles++;
                if (cycles > cycle_limit)
                        abort_run($sformatf("Timeout after %0d cycles without finishing", cycles));
        end

        // Write protocol and EP2 sequence, checked mid-cycle
        always @(negedge usbclk) begin
                if (arst_n && slwr == 1'b0 && flagc == 1'b0)
                        abort_run("slwr went low while EP2 had no room");
                if (arst_n && slwr == 1'b0 && (fd_oe !== 1'b1 || fifoadr !== ADR_EP2))
                        abort_run("EP2 write without fd_oe or away from the EP2 address");
                if (arst_n && sloe == 1'b0 && fd_oe !== 1'b0)
                        abort_run("fd_oe high while the bridge drives fd");
                if (host.ep2_log.size() > checked) begin
                        check_word($sformatf("ep2 word %0d", checked), host.ep2_log[checked],
                                   exp_pattern(round_base, round_step, checked - round_start));
                        checked++;
                end
        end

        task automatic next_cycle();
                @(posedge usbclk);
                #1;
        endtask

        task automatic wait_drained();
                while (host.ep6_q.size() != 0 || host.ep8_q.size() != 0)
                        next_cycle();
                repeat (4) next_cycle();        // Last word reaches the registers
        endtask

        // Every digit select must show the decode of its nibble
        task automatic check_display(input word_t value);
                logic [3:0] seen;
                int         d;
                int         n_on;
                seen = '0;
                repeat (DIGITS * SCAN_DIV + 2) begin
                        next_cycle();
                        d    = 0;
                        n_on = 0;
                        for (int i = 0; i < DIGITS; i++) begin
                                if (ledseg[i] == 1'b0) begin
                                        d = i;
                                        n_on++;
                                end
                        end
                        if (n_on != 1)
                                abort_run("ledseg did not select exactly one digit");
                        seen[d] = 1'b1;
                        check_byte($sformatf("seg_d digit %0d", d), seg_d,
                                   ref_seg(value[d*4 +: 4]));
                end
                if (seen != 4'hf)
                        abort_run("Not every digit was selected during a full scan");
        endtask

        // Generator on for n words, EP2 room handed out in random bursts
        task automatic run_round(input logic [7:0] step, input int n);
                logic [31:0] r;
                int          stall;
                int          pkt_before;
                stall      = 0;
                pkt_before = host.pktend_cnt;
                round_step = step;
                host.load_ep8({REG_STEP, 4'h0, step});
                host.load_ep8({REG_CTRL, 12'h001});
                while (host.ep2_log.size() < round_start + n) begin
                        next_cycle();
                        if (host.ep2_room == 0)
                                stall++;
                        if (stall == 4) begin
                                draw(3, r);
                                host.add_room(int'(r[2:0]) + 1);
                                stall = 0;
                        end
                end
                host.load_ep8({REG_CTRL, 12'h000});     // Disable commits the short packet
                repeat (12) next_cycle();
                check_count("ep2 word count", host.ep2_log.size(), round_start + n);
                check_count("pktend pulses", host.pktend_cnt - pkt_before, exp_pktends(n));
                round_base  = exp_pattern(round_base, step, n);
                round_start = round_start + n;
        endtask

        initial begin
                logic [31:0] r;
                logic [3:0]  adr;
                logic [7:0]  step1;
                logic [7:0]  step2;
                int          n1, n2, n6, n8;
                int          words_before;
                int          read_base;
                word_t       sum;
                word_t       w;
                arst_n = 1'b0;
                draw(8, r);
                step1 = r[7:0] | 8'h01;
                draw(8, r);
                step2 = r[7:0] | 8'h01;
                draw(5, r);
                n1 = int'(r[4:0]) + 1;
                draw(1, r);
                n2 = PKT_WORDS * (int'(r[0]) + 1);     // Whole packets, no pktend
                draw(3, r);
                n6 = int'(r[2:0]) + 4;
                draw(2, r);
                n8 = int'(r[1:0]) + 2;
                cycle_limit = 4 * 3 * (n1 + n2 + 2 * n6 + n8 + 8) + 2000;
                repeat (16) @(posedge usbclk);
                #1 arst_n = 1'b1;

                // Room is open, so only a disabled generator keeps EP2 quiet
                host.add_room(4);
                repeat (8) begin
                        next_cycle();
                        check_byte("{slcs,sloe,slrd,slwr,pktend,fd_oe}",
                                   {2'b00, slcs, sloe, slrd, slwr, pktend, fd_oe}, 8'h1e);
                end
                check_count("ep2 words after reset", host.ep2_log.size(), 0);

                run_round(step1, n1);
                run_round(step2, n2);

                sum = '0;
                for (int k = 0; k < n6; k++) begin
                        draw(16, r);
                        w   = r[15:0];
                        sum = sum_add(sum, w);
                        host.load_ep6(w);
                end
                wait_drained();
                host.load_ep8({REG_CTRL, 12'h002});     // Sum on the display
                wait_drained();
                check_display(sum);
                host.load_ep8({REG_SUM_CLR, 12'h000});
                wait_drained();
                check_display(16'h0000);

                // Unknown addresses carry an enable bit that must not land
                host.add_room(8);
                words_before = host.ep2_log.size();
                read_base    = host.read_log.size();
                sum          = '0;
                for (int k = 0; k < n8; k++) begin
                        draw(4, r);
                        adr = 4'(3 + r % 13);
                        draw(12, r);
                        host.load_ep8({adr, r[11:2], 2'b01});
                end
                for (int k = 0; k < n6; k++) begin
                        draw(16, r);
                        w   = r[15:0];
                        sum = sum_add(sum, w);
                        host.load_ep6(w);
                end
                wait_drained();
                check_count("OUT reads", host.read_log.size() - read_base, n8 + n6);
                for (int k = 0; k < n8 + n6; k++) begin
                        if (k < n8)
                                check_adr($sformatf("read %0d", k), host.read_log[read_base + k],
                                          ADR_EP8);
                        else
                                check_adr($sformatf("read %0d", k), host.read_log[read_base + k],
                                          ADR_EP6);
                end
                check_display(sum);
                check_count("ep2 words after unknown writes", host.ep2_log.size(), words_before);

                $display("Simulation PASSED");
                $finish;
        end

endmodule

`default_nettype wire
